//--- logic/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] wordT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    // Operand source select in EX
    typedef logic [1:0]  fwdSelT;

    // Primary opcodes
    localparam opcodeT opR    = 6'h00;
    localparam opcodeT opAddi = 6'h08;
    localparam opcodeT opLw   = 6'h23;
    localparam opcodeT opSw   = 6'h2b;
    localparam opcodeT opBeq  = 6'h04;
    localparam opcodeT opHalt = 6'h3f;

    // R-type funct field
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr  = 6'h25;
    localparam functT fnSlt = 6'h2a;

    // Forwarding select codes
    localparam fwdSelT fwdReg   = 2'd0;
    localparam fwdSelT fwdExMem = 2'd1;
    localparam fwdSelT fwdMemWb = 2'd2;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

    ////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////

    // All zero means bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        aluOpT aluOp;
        logic  isHalt;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;       // Already resolved destination
        wordT    rsData;
        wordT    rtData;
        wordT    imm;
    } idExT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    aluResult;
        wordT    storeData;
        regAddrT dest;
    } exMemT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    result;
        regAddrT dest;
    } memWbT;

endpackage

//--- logic/hazardDetector.sv
`timescale 1ns/1ps

module hazardDetector
    import mipsPkg::*;
(
    input  ifIdT  ifId,
    input  idExT  idEx,
    input  exMemT exMem,
    output logic  pcWrite,
    output logic  ifIdWrite,
    output logic  stall
);

    opcodeT  op;
    regAddrT rs;
    regAddrT rt;
    logic    readsRs;
    logic    readsRt;
    logic    isBranch;
    logic    loadUse;
    logic    rsBusy;
    logic    rtBusy;
    logic    branchWait;

    // Fields of the instruction in decode
    assign op = ifId.instr[31:26];
    assign rs = ifId.instr[25:21];
    assign rt = ifId.instr[20:16];

    // Which source registers decode actually reads
    assign readsRs  = ifId.valid && (op != opHalt);
    assign readsRt  = ifId.valid && (op == opR || op == opSw || op == opBeq);
    assign isBranch = ifId.valid && (op == opBeq);

    // Load in EX, consumer in ID
    assign loadUse = idEx.ctrl.memRead && (idEx.rt != '0) &&
                     ((readsRs && idEx.rt == rs) || (readsRt && idEx.rt == rt));

    // Branch compares in ID, so any writer in EX is too late
    // Loads in MEM too, ALU results in MEM get forwarded to the comparator
    assign rsBusy = (rs != '0) &&
                    ((idEx.ctrl.regWrite && idEx.rd == rs) ||
                     (exMem.ctrl.memRead && exMem.dest == rs));
    assign rtBusy = (rt != '0) &&
                    ((idEx.ctrl.regWrite && idEx.rd == rt) ||
                     (exMem.ctrl.memRead && exMem.dest == rt));
    assign branchWait = isBranch && (rsBusy || rtBusy);

    always_comb begin
        // Default is free flow
        pcWrite   = 1'b1;
        ifIdWrite = 1'b1;
        stall     = 1'b0;
        if (loadUse || branchWait) begin
            // Freeze front end, bubble into ID/EX
            pcWrite   = 1'b0;
            ifIdWrite = 1'b0;
            stall     = 1'b1;
        end
    end

endmodule

//--- logic/forwardingUnit.sv
`timescale 1ns/1ps

module forwardingUnit
    import mipsPkg::*;
(
    input  idExT   idEx,
    input  exMemT  exMem,
    input  memWbT  memWb,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    // Youngest writer first, r0 never forwarded
    function automatic fwdSelT pickSource(
        input regAddrT src,
        input exMemT   em,
        input memWbT   mw
    );
        fwdSelT sel;
        sel = fwdReg;
        if (src != '0) begin
            if (em.ctrl.regWrite && em.dest == src) begin
                sel = fwdExMem;
            end else if (mw.ctrl.regWrite && mw.dest == src) begin
                sel = fwdMemWb;
            end
        end
        return sel;
    endfunction

    // Operand A from rs
    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    // Operand B from rt, also the store data path
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

endmodule

//--- logic/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder
    import mipsPkg::*;
(
    input  wordT instr,
    output ctrlT ctrl,
    output logic isBranch
);

    opcodeT op;
    functT  fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        // Unknown codes decode to a bubble
        ctrl     = '0;
        isBranch = 1'b0;
        case (op)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (fn)
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl       = '0;
                endcase
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                // Address is rs plus offset
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                // Resolved in ID, nothing left to do downstream
                isBranch = 1'b1;
            end
            opHalt: begin
                ctrl.isHalt = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    we,
    input  regAddrT waddr,
    input  regAddrT raddrA,
    input  regAddrT raddrB,
    input  regAddrT dbgAddr,
    input  wordT    wdata,
    output wordT    rdataA,
    output wordT    rdataB,
    output wordT    dbgData
);

    wordT regs [32];

    // r0 reads zero, same-cycle write bypasses the array
    function automatic wordT readPort(
        input regAddrT ra,
        input wordT    stored,
        input logic    wEn,
        input regAddrT wa,
        input wordT    wd
    );
        wordT val;
        if (ra == '0) begin
            val = '0;
        end else if (wEn && wa == ra) begin
            val = wd;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdataA  = readPort(raddrA, regs[raddrA], we, waddr, wdata);
    assign rdataB  = readPort(raddrB, regs[raddrB], we, waddr, wdata);
    assign dbgData = readPort(dbgAddr, regs[dbgAddr], we, waddr, wdata);

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
    import mipsPkg::*;
(
    input  wordT  a,
    input  wordT  b,
    input  aluOpT op,
    output wordT  result
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluSlt: begin
                // Zero-extended flag
                result = {31'd0, lessThan};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- logic/instrMem.sv
`timescale 1ns/1ps

module instrMem
    import mipsPkg::*;
#(
    parameter int IMEM_WORDS = 256
)
(
    input  logic clk,
    input  logic we,
    input  wordT waddr,
    input  wordT wdata,
    input  wordT pc,
    output wordT instr
);

    // Word index bits of a byte address
    localparam int idxW = $clog2(IMEM_WORDS);

    wordT mem [IMEM_WORDS];

    // Load port, byte address like the PC
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[idxW+1:2]] <= wdata;
        end
    end

    // Fetch
    assign instr = mem[pc[idxW+1:2]];

endmodule

//--- logic/dataMem.sv
`timescale 1ns/1ps

module dataMem
    import mipsPkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic clk,
    input  logic we,
    input  wordT addr,
    input  wordT wdata,
    output wordT rdata
);

    // Low two address bits dropped, word accesses only
    localparam int idxW = $clog2(DMEM_WORDS);

    wordT mem [DMEM_WORDS];

    // Store lands at the end of MEM
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[idxW+1:2]] <= wdata;
        end
    end

    assign rdata = mem[addr[idxW+1:2]];

endmodule

//--- logic/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline
    import mipsPkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    run,
    input  logic    imemWe,
    input  wordT    imemAddr,
    input  wordT    imemWdata,
    input  regAddrT dbgAddr,
    output wordT    dbgData,
    output logic    halted
);

    logic    clear;
    wordT    pc;
    wordT    fetchInstr;
    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;
    ctrlT    idCtrlRaw;
    ctrlT    idCtrl;
    logic    idBranchRaw;
    logic    idBranch;
    regAddrT idRs;
    regAddrT idRt;
    regAddrT idRd;
    regAddrT idDest;
    wordT    idImm;
    wordT    rdataA;
    wordT    rdataB;
    wordT    brA;
    wordT    brB;
    wordT    branchTarget;
    logic    branchTaken;
    logic    haltSeen;
    logic    haltStop;
    logic    pcWrite;
    logic    ifIdWrite;
    logic    stall;
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    wordT    opA;
    wordT    opB;
    wordT    aluB;
    wordT    aluResult;
    wordT    dmemRdata;

    // Run low holds everything at the start state
    assign clear = !rstN || !run;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    instrMem #(.IMEM_WORDS(IMEM_WORDS)) u_instrMem (
        .clk(clk), .we(imemWe && !run), .waddr(imemAddr), .wdata(imemWdata),
        .pc(pc), .instr(fetchInstr)
    );

    // No more fetching once a halt is in decode
    assign haltStop = haltSeen || (ifId.valid && idCtrl.isHalt);

    always_ff @(posedge clk) begin
        if (clear) begin
            pc       <= '0;
            ifId     <= '0;
            haltSeen <= 1'b0;
        end else begin
            if (pcWrite && !haltStop) begin
                pc <= branchTaken ? branchTarget : pc + 32'd4;
            end
            if (ifIdWrite) begin
                // Taken branch flushes the slot behind it
                if (branchTaken || haltStop) begin
                    ifId <= '0;
                end else begin
                    ifId <= '{valid: 1'b1, pc: pc, instr: fetchInstr};
                end
            end
            if (ifId.valid && idCtrl.isHalt) begin
                haltSeen <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Decode and branch
    ////////////////////////////////////////

    assign idRs  = ifId.instr[25:21];
    assign idRt  = ifId.instr[20:16];
    assign idRd  = ifId.instr[15:11];
    assign idImm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

    controlDecoder u_controlDecoder (
        .instr(ifId.instr), .ctrl(idCtrlRaw), .isBranch(idBranchRaw)
    );

    // Invalid slot decodes as bubble
    assign idCtrl   = ifId.valid ? idCtrlRaw : '0;
    assign idBranch = ifId.valid && idBranchRaw;
    // Immediate forms write rt
    assign idDest   = idCtrl.aluSrcImm ? idRt : idRd;

    regFile u_regFile (
        .clk(clk), .we(memWb.ctrl.regWrite), .waddr(memWb.dest),
        .raddrA(idRs), .raddrB(idRt), .dbgAddr(dbgAddr), .wdata(memWb.result),
        .rdataA(rdataA), .rdataB(rdataB), .dbgData(dbgData)
    );

    hazardDetector u_hazardDetector (
        .ifId(ifId), .idEx(idEx), .exMem(exMem),
        .pcWrite(pcWrite), .ifIdWrite(ifIdWrite), .stall(stall)
    );

    // ALU result sitting in MEM feeds the comparator, loads stall instead
    assign brA = (exMem.ctrl.regWrite && !exMem.ctrl.memToReg && exMem.dest != '0 &&
                  exMem.dest == idRs) ? exMem.aluResult : rdataA;
    assign brB = (exMem.ctrl.regWrite && !exMem.ctrl.memToReg && exMem.dest != '0 &&
                  exMem.dest == idRt) ? exMem.aluResult : rdataB;

    assign branchTarget = ifId.pc + 32'd4 + (idImm << 2);
    assign branchTaken  = idBranch && !stall && (brA == brB);

    always_ff @(posedge clk) begin
        if (clear || stall) begin
            idEx <= '0;
        end else begin
            idEx <= '{ctrl: idCtrl, rs: idRs, rt: idRt, rd: idDest,
                      rsData: rdataA, rtData: rdataB, imm: idImm};
        end
    end

    ////////////////////////////////////////
    // Execute
    ////////////////////////////////////////

    forwardingUnit u_forwardingUnit (
        .idEx(idEx), .exMem(exMem), .memWb(memWb), .fwdA(fwdA), .fwdB(fwdB)
    );

    function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal,
                                    input wordT exVal, input wordT wbVal);
        wordT val;
        case (sel)
            fwdExMem: val = exVal;
            fwdMemWb: val = wbVal;
            default:  val = regVal;
        endcase
        return val;
    endfunction

    assign opA  = fwdMux(fwdA, idEx.rsData, exMem.aluResult, memWb.result);
    assign opB  = fwdMux(fwdB, idEx.rtData, exMem.aluResult, memWb.result);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    aluUnit u_aluUnit (.a(opA), .b(aluB), .op(idEx.ctrl.aluOp), .result(aluResult));

    always_ff @(posedge clk) begin
        if (clear) begin
            exMem <= '0;
        end else begin
            // Store data takes the forwarded rt
            exMem <= '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: opB, dest: idEx.rd};
        end
    end

    ////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////

    dataMem #(.DMEM_WORDS(DMEM_WORDS)) u_dataMem (
        .clk(clk), .we(exMem.ctrl.memWrite), .addr(exMem.aluResult),
        .wdata(exMem.storeData), .rdata(dmemRdata)
    );

    always_ff @(posedge clk) begin
        if (clear) begin
            memWb  <= '0;
            halted <= 1'b0;
        end else begin
            memWb <= '{ctrl: exMem.ctrl,
                       result: exMem.ctrl.memToReg ? dmemRdata : exMem.aluResult,
                       dest: exMem.dest};
            // Sticky until run drops
            if (memWb.ctrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- sim/tbMipsPipeline_sva.sv
`timescale 1ns/1ps

module hazardDetectorSva
    import mipsPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic stall,
    input wordT pc,
    input ifIdT ifId,
    input idExT idEx,
    input wordT opA,
    input wordT opB
);

    // Front end keeps its place while the bubble goes in
    stallFreezesFrontEnd: assert property (
        @(posedge clk) disable iff (!rstN) stall |=> $stable(pc) && $stable(ifId)
    ) else $error("PC or IF/ID moved during a stall");

    // Load-use costs one, load ahead of beq two, never more
    stallAtMostTwo: assert property (
        @(posedge clk) disable iff (!rstN) $past(stall) && stall |=> !stall
    ) else $error("stall held for more than two cycles");

    // r0 reaches the ALU as zero, never as a forwarded result
    zeroOperandA: assert property (
        @(posedge clk) disable iff (!rstN) idEx.rs == '0 |-> opA == '0
    ) else $error("register 0 operand A nonzero in execute");
    zeroOperandB: assert property (
        @(posedge clk) disable iff (!rstN) idEx.rt == '0 |-> opB == '0
    ) else $error("register 0 operand B nonzero in execute");

endmodule

bind mipsPipeline hazardDetectorSva u_hazardDetectorSva (
    .clk(clk), .rstN(rstN), .stall(stall), .pc(pc), .ifId(ifId),
    .idEx(idEx), .opA(opA), .opB(opB)
);

//--- sim/tbMipsPipeline.sv
`timescale 1ns/1ps

module tbMipsPipeline
    import mipsPkg::*;
;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    // Six short programs, each well under 150 cycles with load and readback
    localparam int maxCycles = 4000;

    logic    clk = 1'b0;
    logic    rstN = 1'b0;
    logic    run = 1'b0;
    logic    imemWe = 1'b0;
    wordT    imemAddr = '0;
    wordT    imemWdata = '0;
    regAddrT dbgAddr = '0;
    wordT    dbgData;
    logic    halted;

    int      cycleCount = 0;
    int      lastCycles;
    string   testName;
    wordT    prog [$];
    // Architectural state of the reference model
    wordT    modelRegs [32];
    wordT    modelMem [DMEM_WORDS];

    mipsPipeline #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_mipsPipeline (
        .clk(clk), .rstN(rstN), .run(run), .imemWe(imemWe), .imemAddr(imemAddr),
        .imemWdata(imemWdata), .dbgAddr(dbgAddr), .dbgData(dbgData), .halted(halted)
    );

    always #5 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("ERROR: run still going after %0d cycles, halt never seen", maxCycles);
            $display("FAIL: see errors above");
            $fatal(1, "cycle limit reached");
        end
    end

    ////////////////////////////////////////
    // Encoding and checking
    ////////////////////////////////////////

    // add rd, rs, rt
    function automatic wordT rType(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
        return {opR, rs, rt, rd, 5'd0, fn};
    endfunction

    // addi rt, rs, imm and lw/sw rt, imm(rs) and beq rs, rt, imm
    function automatic wordT iType(opcodeT op, regAddrT rt, regAddrT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkEq(input string what, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Runs prog in order, returns edges from first run-high edge to halted
    function automatic int predictRun();
        int      pcIdx;
        int      slots;
        int      steps;
        wordT    ins;
        opcodeT  op;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
        wordT    a;
        wordT    b;
        wordT    immExt;
        wordT    res;
        wordT    addr;
        logic    readsRt;
        logic    stallNow;
        logic    taken;
        logic    isLoad;
        // Writer in ID/EX (w1), loads in ID/EX (l1) and EX/MEM (l2)
        regAddrT w1;
        regAddrT l1;
        regAddrT l2;
        pcIdx = 0;
        slots = 0;
        steps = 0;
        w1 = '0;
        l1 = '0;
        l2 = '0;
        while (prog[pcIdx][31:26] != opHalt && steps < 1000) begin
            ins     = prog[pcIdx];
            op      = ins[31:26];
            rs      = ins[25:21];
            rt      = ins[20:16];
            immExt  = {{16{ins[15]}}, ins[15:0]};
            readsRt = (op == opR) || (op == opSw) || (op == opBeq);
            // Each stall cycle pushes a bubble into EX
            do begin
                stallNow = (l1 != '0) && (l1 == rs || (readsRt && l1 == rt));
                if (op == opBeq) begin
                    if (rs != '0 && (w1 == rs || l2 == rs)) stallNow = 1'b1;
                    if (rt != '0 && (w1 == rt || l2 == rt)) stallNow = 1'b1;
                end
                if (stallNow) begin
                    l2 = l1;
                    w1 = '0;
                    l1 = '0;
                    slots++;
                end
            end while (stallNow);
            a      = modelRegs[rs];
            b      = modelRegs[rt];
            res    = '0;
            dest   = '0;
            isLoad = 1'b0;
            taken  = 1'b0;
            case (op)
                opR: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        fnAdd: res = a + b;
                        fnSub: res = a - b;
                        fnAnd: res = a & b;
                        fnOr:  res = a | b;
                        fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = '0;
                    endcase
                end
                opAddi: begin
                    dest = rt;
                    res  = a + immExt;
                end
                opLw: begin
                    dest   = rt;
                    isLoad = 1'b1;
                    addr   = a + immExt;
                    res    = modelMem[addr[9:2]];
                end
                opSw: begin
                    addr = a + immExt;
                    modelMem[addr[9:2]] = b;
                end
                opBeq: taken = (a == b);
                default: dest = '0;
            endcase
            if (dest != '0) begin
                modelRegs[dest] = res;
            end
            l2 = l1;
            w1 = dest;
            l1 = isLoad ? dest : '0;
            slots++;
            // Flushed fetch slot behind a taken branch
            if (taken) begin
                l2 = l1;
                w1 = '0;
                l1 = '0;
                slots++;
                pcIdx = pcIdx + 1 + int'(immExt);
            end else begin
                pcIdx++;
            end
            steps++;
        end
        return slots + 5;
    endfunction

    ////////////////////////////////////////
    // Program load, run, readback
    ////////////////////////////////////////

    task automatic loadAndRun();
        int expCycles;
        int cycles;
        expCycles = predictRun();
        @(posedge clk);
        run <= 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            imemWe    <= 1'b1;
            imemAddr  <= i * 4;
            imemWdata <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
        run    <= 1'b1;
        cycles = 0;
        // halted sampled mid-cycle, away from the edge
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!halted);
        lastCycles = cycles;
        checkEq("cycles to halt", expCycles, cycles);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbgAddr <= 5'(r);
            @(negedge clk);
            checkEq($sformatf("r%0d", r), modelRegs[r], dbgData);
        end
    endtask

    // Defined values in every register, no hazards
    task automatic fillRegisters();
        testName = "fillRegisters";
        prog.delete();
        for (int r = 1; r < 32; r++) begin
            prog.push_back(iType(opAddi, 5'(r), 5'd0, 16'(r * 3)));
        end
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
        checkEq("hazard-free cycles", 31 + 5, lastCycles);
    endtask

    task automatic forwardChain();
        testName = "forwardChain";
        prog.delete();
        prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd5));
        prog.push_back(iType(opAddi, 5'd2, 5'd1, 16'd7));
        prog.push_back(rType(fnAdd, 5'd3, 5'd1, 5'd2));
        prog.push_back(rType(fnSub, 5'd4, 5'd3, 5'd1));
        prog.push_back(rType(fnAnd, 5'd5, 5'd4, 5'd3));
        prog.push_back(rType(fnOr, 5'd6, 5'd5, 5'd4));
        prog.push_back(rType(fnSlt, 5'd7, 5'd4, 5'd3));
        // -3, then signed compare against 5
        prog.push_back(iType(opAddi, 5'd8, 5'd0, 16'hfffd));
        prog.push_back(rType(fnSlt, 5'd9, 5'd8, 5'd1));
        prog.push_back(rType(fnSub, 5'd10, 5'd0, 5'd9));
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
        checkEq("hazard-free cycles", prog.size() + 4, lastCycles);
    endtask

    task automatic loadUseStall();
        testName = "loadUseStall";
        prog.delete();
        prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd100));
        prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'd8));
        prog.push_back(iType(opSw, 5'd1, 5'd2, 16'd0));
        prog.push_back(iType(opLw, 5'd3, 5'd2, 16'd0));
        prog.push_back(rType(fnAdd, 5'd4, 5'd3, 5'd1));
        // Consumer two behind the load, no stall
        prog.push_back(iType(opLw, 5'd5, 5'd2, 16'd0));
        prog.push_back(iType(opAddi, 5'd6, 5'd0, 16'd1));
        prog.push_back(rType(fnSub, 5'd7, 5'd5, 5'd6));
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
        checkEq("one bubble", prog.size() + 5, lastCycles);
    endtask

    task automatic branchStalls();
        testName = "branchStalls";
        prog.delete();
        prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'd3));
        prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'd3));
        prog.push_back(rType(fnAdd, 5'd3, 5'd1, 5'd0));
        // ALU producer, taken, skips one
        prog.push_back(iType(opBeq, 5'd2, 5'd3, 16'd1));
        prog.push_back(iType(opAddi, 5'd4, 5'd0, 16'd111));
        prog.push_back(iType(opAddi, 5'd5, 5'd0, 16'd4));
        prog.push_back(iType(opSw, 5'd5, 5'd0, 16'd4));
        prog.push_back(iType(opLw, 5'd6, 5'd0, 16'd4));
        // Load producer, not taken
        prog.push_back(iType(opBeq, 5'd1, 5'd6, 16'd1));
        prog.push_back(iType(opAddi, 5'd7, 5'd0, 16'd77));
        prog.push_back(iType(opLw, 5'd8, 5'd0, 16'd4));
        // Load producer, taken, skips two
        prog.push_back(iType(opBeq, 5'd5, 5'd8, 16'd2));
        prog.push_back(iType(opAddi, 5'd9, 5'd0, 16'd9));
        prog.push_back(iType(opAddi, 5'd10, 5'd0, 16'd10));
        prog.push_back(iType(opAddi, 5'd11, 5'd0, 16'd11));
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
    endtask

    task automatic memRoundTrip();
        testName = "memRoundTrip";
        prog.delete();
        prog.push_back(iType(opAddi, 5'd1, 5'd0, 16'h1234));
        // -7
        prog.push_back(iType(opAddi, 5'd2, 5'd0, 16'hfff9));
        prog.push_back(iType(opSw, 5'd1, 5'd0, 16'd16));
        prog.push_back(iType(opSw, 5'd2, 5'd0, 16'd20));
        prog.push_back(iType(opLw, 5'd3, 5'd0, 16'd16));
        prog.push_back(iType(opLw, 5'd4, 5'd0, 16'd20));
        // Writes aimed at r0
        prog.push_back(iType(opAddi, 5'd0, 5'd0, 16'd55));
        prog.push_back(rType(fnAdd, 5'd0, 5'd1, 5'd2));
        prog.push_back(iType(opLw, 5'd0, 5'd0, 16'd16));
        prog.push_back(rType(fnAdd, 5'd6, 5'd0, 5'd1));
        // Overwrite the first word and read it back
        prog.push_back(iType(opSw, 5'd4, 5'd0, 16'd16));
        prog.push_back(iType(opLw, 5'd7, 5'd0, 16'd16));
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
    endtask

    task automatic randomAluProgram();
        int      kind;
        regAddrT rd;
        regAddrT rs;
        regAddrT rt;
        testName = "randomAluProgram";
        prog.delete();
        for (int n = 0; n < 40; n++) begin
            kind = $urandom_range(0, 5);
            rd   = 5'($urandom_range(1, 7));
            rs   = 5'($urandom_range(1, 7));
            rt   = 5'($urandom_range(1, 7));
            case (kind)
                0: prog.push_back(rType(fnAdd, rd, rs, rt));
                1: prog.push_back(rType(fnSub, rd, rs, rt));
                2: prog.push_back(rType(fnAnd, rd, rs, rt));
                3: prog.push_back(rType(fnOr, rd, rs, rt));
                4: prog.push_back(rType(fnSlt, rd, rs, rt));
                default: prog.push_back(iType(opAddi, rd, rs, 16'($urandom)));
            endcase
        end
        prog.push_back({opHalt, 26'd0});
        loadAndRun();
        checkEq("hazard-free cycles", 40 + 5, lastCycles);
    endtask

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    initial begin
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        foreach (modelMem[i]) begin
            modelMem[i] = '0;
        end
        void'($urandom(47));
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        fillRegisters();
        forwardChain();
        loadUseStall();
        branchStalls();
        memRoundTrip();
        randomAluProgram();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- build.f
logic/mipsPkg.sv
logic/hazardDetector.sv
logic/forwardingUnit.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/instrMem.sv
logic/dataMem.sv
logic/mipsPipeline.sv
sim/tbMipsPipeline_sva.sv
sim/tbMipsPipeline.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tbMipsPipeline \
		-Mdir obj_dir -f build.f
	./obj_dir/VtbMipsPipeline

clean:
	rm -rf obj_dir
